// ==== verilog/vuart_pkg.sv ====
/* types and address map shared by the virtual UART CSR front end
   addresses are 12-bit byte offsets, the UART side starts at UART_BASE */
package vuart_pkg;

   // --------------------------------------------------
   // address map
   // --------------------------------------------------
   localparam logic [11:0] UART_BASE       = 12'h200;
   localparam logic [11:0] DFH_SCRATCH_OFS = 12'h008;

   // write width of a request
   typedef enum logic [1:0] {
      ACC_FULL64  = 2'd0,
      ACC_LOWER32 = 2'd1,
      ACC_UPPER32 = 2'd2  // data sits in wdata[63:32]
   } csr_access_t;

   // --------------------------------------------------
   // request / response structs
   // --------------------------------------------------
   typedef struct packed {
      logic        write;
      logic        read;
      logic [11:0] addr;
      csr_access_t access;
      logic [63:0] wdata;
   } csr_req_t;  // 80 bits

   typedef struct packed {
      logic        valid;
      logic [63:0] rdata;
   } csr_rsp_t;

   typedef struct packed {
      logic        write;
      logic        read;
      logic [11:0] addr;
      csr_access_t access;
      logic [63:0] wdata;
   } dfh_req_t;

   typedef struct packed {
      logic        write;
      logic        read;
      logic [8:0]  addr;
      logic [31:0] wdata;
   } uart_req_t;

endpackage

// ==== verilog/csr_req_fifo.sv ====
`timescale 1ns/1ps
/* single-clock show-ahead queue of host requests
   ready is registered and falls once the fill count reaches READY_THRESHOLD,
   the writer must not push while ready is low */
module csr_req_fifo #(
   parameter int FIFO_DEPTH_LOG2 = 4,
   parameter int READY_THRESHOLD = 10
) (
   input  logic                clk_50m,
   input  logic                rst_n_50m,
   input  logic                push,
   input  vuart_pkg::csr_req_t wdata,
   input  logic                pop,
   output vuart_pkg::csr_req_t head,
   output logic                empty,
   output logic                ready
);
   import vuart_pkg::*;

   localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

   csr_req_t                   mem [DEPTH];
   logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
   logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
   logic [FIFO_DEPTH_LOG2:0]   count;
   logic [FIFO_DEPTH_LOG2:0]   count_nxt;

   always_ff @(posedge clk_50m) begin
      if (push) begin
         mem[wr_ptr] <= wdata;
      end
   end

   always_comb begin
      case ({push, pop})
         2'b10:   count_nxt = count + 1'b1;
         2'b01:   count_nxt = count - 1'b1;
         default: count_nxt = count;  // idle or push+pop
      endcase
   end

   always_ff @(posedge clk_50m) begin
      if (!rst_n_50m) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         ready  <= 1'b1;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count_nxt;
         ready <= (count_nxt < (FIFO_DEPTH_LOG2 + 1)'(READY_THRESHOLD));  // almost full
      end
   end

   assign head  = mem[rd_ptr];  // show-ahead
   assign empty = (count == '0);

endmodule

// ==== verilog/vuart_csr_decode.sv ====
`timescale 1ns/1ps
/* pops one queued request at a time and routes it by offset
   only one read is outstanding at any time, so responses keep request order
   DFH requests leave one cycle after the pop, UART requests in the pop cycle */
module vuart_csr_decode (
   input  logic                 clk_50m,
   input  logic                 rst_n_50m,
   input  vuart_pkg::csr_req_t  head,
   input  logic                 empty,
   output logic                 pop,
   output vuart_pkg::uart_req_t uart_req,
   input  logic [31:0]          uart_rdata,
   input  logic                 uart_rvalid,
   output vuart_pkg::dfh_req_t  dfh_req,
   input  logic [63:0]          dfh_rdata,
   input  logic                 dfh_rvalid,
   output vuart_pkg::csr_rsp_t  rsp
);
   import vuart_pkg::*;

   logic        head_uart;
   logic        pop_uart;
   logic        pop_dfh;
   logic        uart_rd_ip;
   logic        dfh_rd_ip;
   logic        dfh_wr_q;
   logic        dfh_rd_q;
   logic [11:0] dfh_addr_q;
   csr_access_t dfh_access_q;
   logic [63:0] dfh_wdata_q;

   assign head_uart = (head.addr >= UART_BASE);
   assign pop       = ~empty & ~uart_rd_ip & ~dfh_rd_ip;
   assign pop_uart  = pop & head_uart;
   assign pop_dfh   = pop & ~head_uart;

   // --------------------------------------------------
   // UART side, combinational in the pop cycle
   // --------------------------------------------------
   always_comb begin
      uart_req.write = pop_uart & head.write;
      uart_req.read  = pop_uart & head.read;
      uart_req.addr  = head.addr[8:0];
      uart_req.wdata = (head.access == ACC_UPPER32) ? head.wdata[63:32] : head.wdata[31:0];
   end

   // --------------------------------------------------
   // DFH side, one register stage
   // --------------------------------------------------
   always_ff @(posedge clk_50m) begin
      if (!rst_n_50m) begin
         dfh_wr_q <= 1'b0;
         dfh_rd_q <= 1'b0;
      end else begin
         dfh_wr_q <= pop_dfh & head.write;
         dfh_rd_q <= pop_dfh & head.read;
      end
   end

   always_ff @(posedge clk_50m) begin
      dfh_addr_q   <= head.addr;
      dfh_access_q <= head.access;
      dfh_wdata_q  <= head.wdata;
   end

   always_comb begin
      dfh_req.write  = dfh_wr_q;
      dfh_req.read   = dfh_rd_q;
      dfh_req.addr   = dfh_addr_q;
      dfh_req.access = dfh_access_q;
      dfh_req.wdata  = dfh_wdata_q;
   end

   // read in flight, one flag per side
   always_ff @(posedge clk_50m) begin
      if (!rst_n_50m) begin
         uart_rd_ip <= 1'b0;
         dfh_rd_ip  <= 1'b0;
      end else begin
         uart_rd_ip <= uart_req.read | (uart_rd_ip & ~uart_rvalid);
         dfh_rd_ip  <= (pop_dfh & head.read) | (dfh_rd_ip & ~dfh_rvalid);
      end
   end

   // both returns come straight from registers
   always_comb begin
      rsp.valid = uart_rvalid | dfh_rvalid;
      rsp.rdata = dfh_rvalid ? dfh_rdata : {uart_rdata, uart_rdata};  // uart word on both halves
   end

endmodule

// ==== verilog/vuart_dfh_regs.sv ====
`timescale 1ns/1ps
/* device feature header at offset 0 and a 64-bit scratch register at 8
   any other offset reads zero, writes to it are lost
   read data returns two cycles after the request */
module vuart_dfh_regs #(
   parameter logic [63:0] DFH_VALUE = 64'h3000_0000_0001_0024
) (
   input  logic                clk_50m,
   input  logic                rst_n_50m,
   input  vuart_pkg::dfh_req_t dfh_req,
   output logic [63:0]         dfh_rdata,
   output logic                dfh_rvalid
);
   import vuart_pkg::*;

   logic [63:0] scratch;
   logic [63:0] rd_mux;
   logic        rd_vld_q;
   logic [63:0] rd_data_q;
   logic        scratch_hit;

   assign scratch_hit = (dfh_req.addr == DFH_SCRATCH_OFS);

   always_ff @(posedge clk_50m) begin
      if (!rst_n_50m) begin
         scratch <= '0;
      end else if (dfh_req.write && scratch_hit) begin
         case (dfh_req.access)
            ACC_LOWER32: scratch[31:0]  <= dfh_req.wdata[31:0];
            ACC_UPPER32: scratch[63:32] <= dfh_req.wdata[63:32];
            default:     scratch        <= dfh_req.wdata;
         endcase
      end
   end

   always_comb begin
      case (dfh_req.addr)
         12'h000:         rd_mux = DFH_VALUE;
         DFH_SCRATCH_OFS: rd_mux = scratch;
         default:         rd_mux = '0;
      endcase
   end

   // --------------------------------------------------
   // two-stage read return
   // --------------------------------------------------
   always_ff @(posedge clk_50m) begin
      if (!rst_n_50m) begin
         rd_vld_q   <= 1'b0;
         dfh_rvalid <= 1'b0;
      end else begin
         rd_vld_q   <= dfh_req.read;
         dfh_rvalid <= rd_vld_q;
      end
   end

   always_ff @(posedge clk_50m) begin
      rd_data_q <= rd_mux;
      dfh_rdata <= rd_data_q;
   end

endmodule

// ==== verilog/uart_reg_file.sv ====
`timescale 1ns/1ps
/* 16550-style register map, byte registers 8 bytes apart (addr[5:3])
   no serializer: THR data is dropped, RBR reads 0, LSR always says tx empty */
module uart_reg_file (
   input  logic                 clk_50m,
   input  logic                 rst_n_50m,
   input  vuart_pkg::uart_req_t uart_req,
   output logic [31:0]          uart_rdata,
   output logic                 uart_rvalid
);

   typedef enum logic [2:0] {
      REG_RBR = 3'd0,
      REG_IER = 3'd1,
      REG_IIR = 3'd2,
      REG_LCR = 3'd3,
      REG_MCR = 3'd4,
      REG_LSR = 3'd5,
      REG_MSR = 3'd6,
      REG_SCR = 3'd7
   } uart_reg_e;

   uart_reg_e  idx;
   logic       dlab;
   logic [7:0] wr_byte;
   logic [7:0] dll;
   logic [7:0] dlm;
   logic [3:0] ier;
   logic [7:0] lcr;
   logic [4:0] mcr;
   logic [7:0] scr;
   logic [7:0] rd_byte;

   assign idx     = uart_reg_e'(uart_req.addr[5:3]);
   assign dlab    = lcr[7];
   assign wr_byte = uart_req.wdata[7:0];

   always_ff @(posedge clk_50m) begin
      if (!rst_n_50m) begin
         dll <= 8'h00;
         dlm <= 8'h00;
         ier <= 4'h0;
         lcr <= 8'h03;  // 8N1
         mcr <= 5'h00;
         scr <= 8'h00;
      end else if (uart_req.write) begin
         case (idx)
            REG_RBR: begin
               if (dlab) begin
                  dll <= wr_byte;
               end
            end
            REG_IER: begin
               if (dlab) begin
                  dlm <= wr_byte;
               end else begin
                  ier <= wr_byte[3:0];
               end
            end
            REG_LCR: lcr <= wr_byte;
            REG_MCR: mcr <= wr_byte[4:0];
            REG_SCR: scr <= wr_byte;
            default: ;  // IIR, LSR, MSR read only
         endcase
      end
   end

   always_comb begin
      case (idx)
         REG_RBR: rd_byte = dlab ? dll : 8'h00;
         REG_IER: rd_byte = dlab ? dlm : {4'h0, ier};
         REG_IIR: rd_byte = 8'h01;  // no irq pending
         REG_LCR: rd_byte = lcr;
         REG_MCR: rd_byte = {3'b000, mcr};
         REG_LSR: rd_byte = 8'h60;  // THRE | TEMT
         REG_MSR: rd_byte = 8'h00;
         REG_SCR: rd_byte = scr;
         default: rd_byte = 8'h00;
      endcase
   end

   always_ff @(posedge clk_50m) begin
      if (!rst_n_50m) begin
         uart_rvalid <= 1'b0;
      end else begin
         uart_rvalid <= uart_req.read;
      end
   end

   always_ff @(posedge clk_50m) begin
      uart_rdata <= {24'h0, rd_byte};
   end

endmodule

// ==== verilog/vuart_top.sv ====
`timescale 1ns/1ps
/* virtual UART control-register front end, single clock
   host holds off while ready is low, read data returns in request order */
module vuart_top #(
   parameter int          FIFO_DEPTH_LOG2 = 4,
   parameter int          READY_THRESHOLD = 10,
   parameter logic [63:0] DFH_VALUE       = 64'h3000_0000_0001_0024
) (
   input  logic                clk_50m,
   input  logic                rst_n_50m,
   input  vuart_pkg::csr_req_t req,
   output logic                ready,
   output vuart_pkg::csr_rsp_t rsp
);
   import vuart_pkg::*;

   logic        push;
   csr_req_t    fifo_head;
   logic        fifo_empty;
   logic        fifo_pop;
   uart_req_t   uart_req;
   logic [31:0] uart_rdata;
   logic        uart_rvalid;
   dfh_req_t    dfh_req;
   logic [63:0] dfh_rdata;
   logic        dfh_rvalid;

   assign push = (req.write | req.read) & ready;  // accepted request

   csr_req_fifo #(
      .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2),
      .READY_THRESHOLD (READY_THRESHOLD)
   ) i_csr_req_fifo (
      .clk_50m   (clk_50m),
      .rst_n_50m (rst_n_50m),
      .push      (push),
      .wdata     (req),
      .pop       (fifo_pop),
      .head      (fifo_head),
      .empty     (fifo_empty),
      .ready     (ready)
   );

   vuart_csr_decode i_vuart_csr_decode (
      .clk_50m     (clk_50m),
      .rst_n_50m   (rst_n_50m),
      .head        (fifo_head),
      .empty       (fifo_empty),
      .pop         (fifo_pop),
      .uart_req    (uart_req),
      .uart_rdata  (uart_rdata),
      .uart_rvalid (uart_rvalid),
      .dfh_req     (dfh_req),
      .dfh_rdata   (dfh_rdata),
      .dfh_rvalid  (dfh_rvalid),
      .rsp         (rsp)
   );

   vuart_dfh_regs #(
      .DFH_VALUE (DFH_VALUE)
   ) i_vuart_dfh_regs (
      .clk_50m    (clk_50m),
      .rst_n_50m  (rst_n_50m),
      .dfh_req    (dfh_req),
      .dfh_rdata  (dfh_rdata),
      .dfh_rvalid (dfh_rvalid)
   );

   uart_reg_file i_uart_reg_file (
      .clk_50m     (clk_50m),
      .rst_n_50m   (rst_n_50m),
      .uart_req    (uart_req),
      .uart_rdata  (uart_rdata),
      .uart_rvalid (uart_rvalid)
   );

endmodule

// ==== tests/vuart_asserts.sv ====
`timescale 1ns/1ps
/* concurrent checks bound into the CSR decoder and the request FIFO
   inputs that a block does not have are tied low at its bind */
module vuart_asserts (
   input logic clk_50m,
   input logic rst_n_50m,
   input logic uart_rd,
   input logic dfh_rd,
   input logic rsp_valid,
   input logic rd_in_flight,
   input logic push,
   input logic full
);

   // a DFH write may meet a UART access, two reads never do
   read_strobes_exclusive: assert property (
      @(posedge clk_50m) disable iff (!rst_n_50m) !(uart_rd && dfh_rd))
      else $error("UART and DFH read strobes active in the same cycle");

   rsp_needs_read: assert property (
      @(posedge clk_50m) disable iff (!rst_n_50m) rsp_valid |-> rd_in_flight)
      else $error("read response without a read in flight");

   no_push_when_full: assert property (
      @(posedge clk_50m) disable iff (!rst_n_50m) !(push && full))
      else $error("request FIFO pushed while full");

endmodule

bind vuart_csr_decode vuart_asserts i_decode_asserts (
   .clk_50m      (clk_50m),
   .rst_n_50m    (rst_n_50m),
   .uart_rd      (uart_req.read),
   .dfh_rd       (dfh_req.read),
   .rsp_valid    (rsp.valid),
   .rd_in_flight (uart_rd_ip | dfh_rd_ip),
   .push         (1'b0),
   .full         (1'b0)
);

bind csr_req_fifo vuart_asserts i_fifo_asserts (
   .clk_50m      (clk_50m),
   .rst_n_50m    (rst_n_50m),
   .uart_rd      (1'b0),
   .dfh_rd       (1'b0),
   .rsp_valid    (1'b0),
   .rd_in_flight (1'b0),
   .push         (push),
   .full         (count[FIFO_DEPTH_LOG2])  // msb set only at full depth
);

// ==== tests/vuart_tb.sv ====
`timescale 1ns/1ps
/* testbench for vuart_top with FIFO depth 16 and ready threshold 10
   requests are driven 1 ns after the rising edge, responses sampled on the falling edge */
module vuart_tb;
   import vuart_pkg::*;

   localparam logic [63:0] TB_DFH = 64'h3000_0000_2001_0024;

   logic        clk_50m = 1'b0;
   logic        rst_n_50m;
   csr_req_t    req;
   logic        ready;
   csr_rsp_t    rsp;
   logic [31:0] lfsr_state = 32'hbb56_42df;
   logic [63:0] exp_q[$];
   int          read_count = 0;
   int          rsp_count = 0;
   logic        saw_full = 1'b0;
   // register map model
   logic [63:0] m_scratch = '0;
   logic [7:0]  m_dll = 8'h00;
   logic [7:0]  m_dlm = 8'h00;
   logic [3:0]  m_ier = 4'h0;
   logic [7:0]  m_lcr = 8'h03;
   logic [4:0]  m_mcr = 5'h00;
   logic [7:0]  m_scr = 8'h00;

   vuart_top #(
      .FIFO_DEPTH_LOG2 (4),
      .READY_THRESHOLD (10),
      .DFH_VALUE       (TB_DFH)
   ) i_vuart_top (
      .clk_50m   (clk_50m),
      .rst_n_50m (rst_n_50m),
      .req       (req),
      .ready     (ready),
      .rsp       (rsp)
   );

   always #10 clk_50m = ~clk_50m;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // taps 32 22 2 1
   endfunction

   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         v = {v[62:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
      return v;
   endfunction

   // --------------------------------------------------
   // reference model, returns the expected read data
   // --------------------------------------------------
   function automatic logic [63:0] model_apply(input csr_req_t r);
      logic [7:0]  b;
      logic [7:0]  rd;
      logic [63:0] res;
      logic        dlab;
      dlab = m_lcr[7];
      b    = (r.access == ACC_UPPER32) ? r.wdata[39:32] : r.wdata[7:0];
      rd   = 8'h00;
      if (r.addr < UART_BASE) begin
         if (r.write && r.addr == DFH_SCRATCH_OFS) begin
            case (r.access)
               ACC_LOWER32: m_scratch[31:0] = r.wdata[31:0];
               ACC_UPPER32: m_scratch[63:32] = r.wdata[63:32];
               default:     m_scratch = r.wdata;
            endcase
         end
         res = (r.addr == 12'h000) ? TB_DFH : (r.addr == DFH_SCRATCH_OFS) ? m_scratch : '0;
      end else begin
         if (r.write) begin
            case (r.addr[5:3])
               3'd0: if (dlab) m_dll = b;  // THR is dropped
               3'd1: begin
                  if (dlab) begin
                     m_dlm = b;
                  end else begin
                     m_ier = b[3:0];
                  end
               end
               3'd3: m_lcr = b;
               3'd4: m_mcr = b[4:0];
               3'd7: m_scr = b;
               default: ;
            endcase
         end
         case (r.addr[5:3])
            3'd0:    rd = dlab ? m_dll : 8'h00;
            3'd1:    rd = dlab ? m_dlm : {4'h0, m_ier};
            3'd2:    rd = 8'h01;
            3'd3:    rd = m_lcr;
            3'd4:    rd = {3'b000, m_mcr};
            3'd5:    rd = 8'h60;
            3'd6:    rd = 8'h00;
            default: rd = m_scr;
         endcase
         res = {24'h0, rd, 24'h0, rd};
      end
      return res;
   endfunction

   task automatic abort_run();
      $display("TEST FAILED");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("Fail %0t ns: %s, got %h, expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic send_req(input csr_req_t r);
      int waited;
      waited = 0;
      while (!ready) begin
         saw_full = 1'b1;
         if (waited == 200) begin
            $display("timeout: ready stayed low for 200 cycles");
            abort_run();
         end
         waited++;
         @(posedge clk_50m);
         #1;
      end
      req = r;
      if (r.read) begin
         exp_q.push_back(model_apply(r));
         read_count++;
      end else begin
         void'(model_apply(r));
      end
      @(posedge clk_50m);
      #1;
      req = '0;
   endtask

   task automatic write_reg(input logic [11:0] addr, input csr_access_t acc,
                            input logic [63:0] data);
      csr_req_t r;
      r = '{write: 1'b1, read: 1'b0, addr: addr, access: acc, wdata: data};
      send_req(r);
   endtask

   task automatic read_reg(input logic [11:0] addr);
      csr_req_t r;
      r = '{write: 1'b0, read: 1'b1, addr: addr, access: ACC_FULL64, wdata: '0};
      send_req(r);
   endtask

   task automatic random_request(output csr_req_t r);
      logic [63:0] side;
      logic [63:0] sel;
      logic [63:0] acc;
      side = rand_bits(1);
      sel  = rand_bits(6);
      acc  = rand_bits(2);
      r    = '0;
      if (side[0]) begin
         r.addr = UART_BASE + {6'b0, sel[2:0], 3'b000};
      end else if (sel[1:0] == 2'd0) begin
         r.addr = 12'h000;
      end else if (sel[1:0] == 2'd3) begin
         r.addr = {3'b000, sel[5:0], 3'b000};  // unmapped DFH space
      end else begin
         r.addr = DFH_SCRATCH_OFS;
      end
      r.access = (acc[1:0] == 2'd3) ? ACC_FULL64 : csr_access_t'(acc[1:0]);
      r.wdata  = rand_bits(64);
      side     = rand_bits(1);
      r.write  = side[0];
      r.read   = ~side[0];
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (exp_q.size() != 0) begin
         if (waited == 500) begin
            $display("timeout: %0d read responses never arrived", exp_q.size());
            abort_run();
         end
         waited++;
         @(posedge clk_50m);
         #1;
      end
   endtask

   // compare process
   always @(negedge clk_50m) begin
      if (rst_n_50m && rsp.valid) begin
         if (exp_q.size() == 0) begin
            $display("read response at %0t ns with no read outstanding", $time);
            abort_run();
         end else begin
            check_value("read data", rsp.rdata, exp_q.pop_front());
            rsp_count++;
         end
      end
   end

   initial begin
      csr_req_t    r;
      logic [63:0] gap;
      req       = '0;
      rst_n_50m = 1'b0;
      repeat (10) @(posedge clk_50m);
      #1;
      rst_n_50m = 1'b1;
      @(posedge clk_50m);
      #1;
      check_value("ready after reset", ready, 1);
      check_value("rsp.valid after reset", rsp.valid, 0);

      // reset values
      read_reg(12'h000);
      read_reg(DFH_SCRATCH_OFS);
      for (int i = 0; i < 8; i++) begin
         read_reg(UART_BASE + 12'(i * 8));
      end
      wait_drain();

      // scratch half-word writes
      write_reg(DFH_SCRATCH_OFS, ACC_FULL64, 64'h0123_4567_89ab_cdef);
      read_reg(DFH_SCRATCH_OFS);
      write_reg(DFH_SCRATCH_OFS, ACC_LOWER32, 64'hdead_beef_1111_2222);
      read_reg(DFH_SCRATCH_OFS);  // upper half must survive
      write_reg(DFH_SCRATCH_OFS, ACC_UPPER32, 64'h5555_6666_7777_8888);
      read_reg(DFH_SCRATCH_OFS);
      read_reg(12'h010);
      wait_drain();

      // byte registers, masks, read-only registers
      write_reg(UART_BASE + 12'h18, ACC_FULL64, 64'h1b);  // LCR
      write_reg(UART_BASE + 12'h20, ACC_LOWER32, 64'hff);  // MCR
      write_reg(UART_BASE + 12'h08, ACC_FULL64, 64'hff);  // IER
      write_reg(UART_BASE + 12'h38, ACC_FULL64, 64'h5a);  // SCR
      write_reg(UART_BASE + 12'h10, ACC_FULL64, 64'hff);
      write_reg(UART_BASE + 12'h28, ACC_FULL64, 64'hff);
      write_reg(UART_BASE + 12'h30, ACC_FULL64, 64'hff);
      for (int i = 0; i < 8; i++) begin
         read_reg(UART_BASE + 12'(i * 8));
      end
      write_reg(UART_BASE + 12'h38, ACC_UPPER32, 64'h0000_00c3_0000_00ff);
      read_reg(UART_BASE + 12'h38);
      wait_drain();

      // DLAB banking
      write_reg(UART_BASE + 12'h18, ACC_FULL64, 64'h83);
      write_reg(UART_BASE, ACC_FULL64, 64'h12);
      write_reg(UART_BASE + 12'h08, ACC_FULL64, 64'h34);
      read_reg(UART_BASE);
      read_reg(UART_BASE + 12'h08);
      write_reg(UART_BASE + 12'h18, ACC_FULL64, 64'h03);
      read_reg(UART_BASE);
      read_reg(UART_BASE + 12'h08);
      write_reg(UART_BASE + 12'h18, ACC_FULL64, 64'h80);
      read_reg(UART_BASE);
      read_reg(UART_BASE + 12'h08);
      write_reg(UART_BASE + 12'h18, ACC_FULL64, 64'h03);
      wait_drain();

      // random burst under back-pressure
      for (int i = 0; i < 300; i++) begin
         random_request(r);
         send_req(r);
         gap = rand_bits(2);
         if (gap[1:0] == 2'd3) begin
            @(posedge clk_50m);
            #1;
         end
      end
      wait_drain();
      check_value("ready dropped under load", saw_full, 1);
      repeat (10) @(posedge clk_50m);

      if (exp_q.size() != 0 || rsp_count != read_count) begin
         $display("%0d responses for %0d reads at end of run", rsp_count, read_count);
         abort_run();
      end else begin
         $display("TEST PASSED");
         $finish;
      end
   end

endmodule

// ==== all.f ====
verilog/vuart_pkg.sv
verilog/csr_req_fifo.sv
verilog/vuart_csr_decode.sv
verilog/vuart_dfh_regs.sv
verilog/uart_reg_file.sv
verilog/vuart_top.sv
tests/vuart_asserts.sv
tests/vuart_tb.sv

// ==== Makefile ====
# Verilator simulation of the virtual UART CSR front end

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module vuart_tb \
		-Mdir obj_dir -f all.f
	./obj_dir/Vvuart_tb

clean:
	rm -rf obj_dir
